// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/decode_unit.sv ====
`timescale 1ns/10ps

module decode_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  logic      redirect,
    input  if_id_t    if_id,
    input  reg_addr_t wb_addr,
    input  logic      wb_we,
    input  word_t     wb_data,
    output id_ex_t    id_ex,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output logic      rs1_used,
    output logic      rs2_used
);

    inst_t   inst;
    logic    [2:0] funct3;
    word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_e alu_f3;
    id_ex_t  dec;

    assign inst   = if_id.inst;
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    reg_file u_rf (
        .clk(clk), .rst(rst),
        .ra0(rs1), .ra1(rs2), .wa(wb_addr), .we(wb_we), .wd(wb_data),
        .rd0(dec.rs1_data), .rd1(dec.rs2_data)
    );

    // Shared by OP and OP-IMM, sub only exists in register form
    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (inst[6:0] == OP_REG && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b010:  alu_f3 = ALU_SLT;
            3'b100:  alu_f3 = ALU_XOR;
            3'b110:  alu_f3 = ALU_OR;
            3'b111:  alu_f3 = ALU_AND;
            default: alu_f3 = ALU_ADD;
        endcase
    end

    always_comb begin
        dec.valid    = if_id.valid;
        dec.pc       = if_id.pc;
        dec.rs1      = rs1;
        dec.rs2      = rs2;
        dec.rd       = inst[11:7];
        dec.rs1_used = 1'b0;
        dec.rs2_used = 1'b0;
        dec.imm      = imm_i;
        dec.reg_we   = 1'b0;
        dec.mem_we   = 1'b0;
        dec.load     = 1'b0;
        dec.a_pc     = 1'b0;
        dec.b_imm    = 1'b0;
        dec.alu_op   = ALU_ADD;
        dec.branch   = BR_NONE;
        dec.wb_sel   = WB_ALU;
        case (inst[6:0])
            OP_LUI: begin
                dec.imm    = imm_u;
                dec.reg_we = 1'b1;
                dec.b_imm  = 1'b1;
                dec.alu_op = ALU_PASS_B;
            end
            OP_JAL: begin
                dec.imm    = imm_j;
                dec.reg_we = 1'b1;
                dec.a_pc   = 1'b1; // ALU forms the target
                dec.b_imm  = 1'b1;
                dec.branch = BR_JAL;
                dec.wb_sel = WB_PC4;
            end
            OP_BRANCH: begin
                dec.imm      = imm_b;
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
                dec.a_pc     = 1'b1;
                dec.b_imm    = 1'b1;
                case (funct3)
                    3'b000:  dec.branch = BR_EQ;
                    3'b001:  dec.branch = BR_NE;
                    3'b100:  dec.branch = BR_LT;
                    default: dec.branch = BR_NONE;
                endcase
            end
            OP_LOAD: begin
                dec.rs1_used = 1'b1;
                dec.reg_we   = 1'b1;
                dec.load     = 1'b1;
                dec.b_imm    = 1'b1;
                dec.wb_sel   = WB_LOAD;
            end
            OP_STORE: begin
                dec.imm      = imm_s;
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
                dec.mem_we   = 1'b1;
                dec.b_imm    = 1'b1;
            end
            OP_IMM: begin
                dec.rs1_used = 1'b1;
                dec.reg_we   = 1'b1;
                dec.b_imm    = 1'b1;
                dec.alu_op   = alu_f3;
            end
            OP_REG: begin
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
                dec.reg_we   = 1'b1;
                dec.alu_op   = alu_f3;
            end
            default: ; // Unknown opcode, no-op
        endcase
    end

    assign rs1_used = dec.rs1_used && if_id.valid;
    assign rs2_used = dec.rs2_used && if_id.valid;

    always_ff @(posedge clk) begin
        id_ex <= dec;
        if (rst || stall || redirect) begin // Bubble
            id_ex.valid  <= 1'b0;
            id_ex.reg_we <= 1'b0;
            id_ex.mem_we <= 1'b0;
            id_ex.load   <= 1'b0;
            id_ex.branch <= BR_NONE;
        end
    end

endmodule

// ==== hw/execute_unit.sv ====
`timescale 1ns/10ps

module execute_unit import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  id_ex_t   id_ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  word_t    mem_wb_data,
    output logic     redirect,
    output word_t    target,
    output ex_mem_t  ex_mem
);

    word_t mem_fwd;
    word_t op_a, op_b;
    word_t alu_a, alu_b;
    word_t alu_res;
    logic  taken;

    // A jal in MEM hands on its link address
    assign mem_fwd = (ex_mem.wb_sel == WB_PC4) ? ex_mem.pc4 : ex_mem.alu;

    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = mem_fwd;
            FWD_WB:  op_a = mem_wb_data;
            default: op_a = id_ex.rs1_data;
        endcase
        case (fwd_b)
            FWD_MEM: op_b = mem_fwd;
            FWD_WB:  op_b = mem_wb_data;
            default: op_b = id_ex.rs2_data;
        endcase
    end

    assign alu_a = id_ex.a_pc ? id_ex.pc : op_a;
    assign alu_b = id_ex.b_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB:    alu_res = alu_a - alu_b;
            ALU_AND:    alu_res = alu_a & alu_b;
            ALU_OR:     alu_res = alu_a | alu_b;
            ALU_XOR:    alu_res = alu_a ^ alu_b;
            ALU_SLT:    alu_res = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (id_ex.branch)
            BR_EQ:   taken = op_a == op_b;
            BR_NE:   taken = op_a != op_b;
            BR_LT:   taken = $signed(op_a) < $signed(op_b);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = id_ex.valid && taken;
    assign target   = alu_res; // pc + imm for branches and jal

    always_ff @(posedge clk) begin
        ex_mem.alu        <= alu_res;
        ex_mem.store_data <= op_b;
        ex_mem.pc4        <= id_ex.pc + 32'd4;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.wb_sel     <= id_ex.wb_sel;
        if (rst) begin
            ex_mem.valid  <= 1'b0;
            ex_mem.reg_we <= 1'b0;
            ex_mem.mem_we <= 1'b0;
        end else begin
            ex_mem.valid  <= id_ex.valid;
            ex_mem.reg_we <= id_ex.valid && id_ex.reg_we;
            ex_mem.mem_we <= id_ex.valid && id_ex.mem_we;
        end
    end

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit import rv_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   stall,
    input  logic   redirect,
    input  word_t  target,
    input  inst_t  inst,
    output word_t  pc,
    output if_id_t if_id
);

    word_t pc_next;

    // Redirect beats stall
    always_comb begin
        if (redirect)
            pc_next = target;
        else if (stall)
            pc_next = pc;
        else
            pc_next = pc + 32'd4; // Not-taken prediction
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            if_id.valid <= 1'b0;
            if_id.inst  <= NOP_INST; // Kill wrong-path fetch
        end else if (!stall) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.inst  <= inst;
        end
    end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit import rv_pkg::*; (
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      rs1_used,
    input  logic      rs2_used,
    input  id_ex_t    id_ex,
    input  ex_mem_t   ex_mem,
    input  mem_wb_t   mem_wb,
    output logic      stall,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b
);

    logic mem_src;
    logic wb_src;

    function automatic logic dep(reg_addr_t rd, logic we, reg_addr_t rs, logic used);
        return we && used && rd != '0 && rd == rs;
    endfunction

    // Load result is not ready until WB
    assign stall = dep(id_ex.rd, id_ex.valid && id_ex.load, rs1, rs1_used) ||
                   dep(id_ex.rd, id_ex.valid && id_ex.load, rs2, rs2_used);

    assign mem_src = ex_mem.valid && ex_mem.reg_we && ex_mem.wb_sel != WB_LOAD;
    assign wb_src  = mem_wb.valid && mem_wb.reg_we;

    always_comb begin
        fwd_a = FWD_RF;
        if (dep(ex_mem.rd, mem_src, id_ex.rs1, id_ex.rs1_used))
            fwd_a = FWD_MEM;
        else if (dep(mem_wb.rd, wb_src, id_ex.rs1, id_ex.rs1_used))
            fwd_a = FWD_WB;

        fwd_b = FWD_RF;
        if (dep(ex_mem.rd, mem_src, id_ex.rs2, id_ex.rs2_used))
            fwd_b = FWD_MEM;
        else if (dep(mem_wb.rd, wb_src, id_ex.rs2, id_ex.rs2_used))
            fwd_b = FWD_WB;
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t ra0,
    input  reg_addr_t ra1,
    input  reg_addr_t wa,
    input  logic      we,
    input  word_t     wd,
    output word_t     rd0,
    output word_t     rd1
);

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write is visible to decode
    assign rd0 = (ra0 == '0) ? '0 : (we && wa == ra0) ? wd : regs[ra0];
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    output word_t im_addr,    // Current PC
    input  inst_t im_dout,

    output word_t mem_addr,
    output logic  mem_we,
    output word_t mem_din,
    input  word_t mem_dout
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   wb_view;
    logic      stall;
    logic      redirect;
    word_t     target;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      rs1_used;
    logic      rs2_used;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    reg_addr_t wb_addr;
    logic      wb_we;
    word_t     wb_data;

    assign mem_addr = ex_mem.alu;
    assign mem_we   = ex_mem.mem_we;
    assign mem_din  = ex_mem.store_data;

    // Hazard unit only looks at valid, reg_we and rd of the WB stage
    assign wb_view = '{valid: wb_we, alu: wb_data, load_data: wb_data, pc4: wb_data,
                       rd: wb_addr, reg_we: wb_we, wb_sel: WB_ALU};

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
        .target(target), .inst(im_dout),
        .pc(im_addr), .if_id(if_id)
    );

    decode_unit u_decode (
        .clk(clk), .rst(rst), .stall(stall), .redirect(redirect), .if_id(if_id),
        .wb_addr(wb_addr), .wb_we(wb_we), .wb_data(wb_data),
        .id_ex(id_ex),
        .rs1(rs1), .rs2(rs2), .rs1_used(rs1_used), .rs2_used(rs2_used)
    );

    hazard_unit u_hazard (
        .rs1(rs1), .rs2(rs2), .rs1_used(rs1_used), .rs2_used(rs2_used),
        .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(wb_view),
        .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    execute_unit u_execute (
        .clk(clk), .rst(rst), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_wb_data(wb_data),
        .redirect(redirect), .target(target), .ex_mem(ex_mem)
    );

    writeback_unit u_writeback (
        .clk(clk), .rst(rst), .ex_mem(ex_mem), .mem_dout(mem_dout),
        .wb_addr(wb_addr), .wb_we(wb_we), .wb_data(wb_data)
    );

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [31:0] NOP_INST = 32'h0000_0013; // addi x0,x0,0

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_JAL} branch_e;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

    typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      rs1_used;
        logic      rs2_used;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rd;
        logic      reg_we;
        logic      mem_we;
        logic      load;
        logic      a_pc;      // PC as ALU operand A
        logic      b_imm;     // Immediate as ALU operand B
        alu_op_e   alu_op;
        branch_e   branch;
        wb_sel_e   wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     alu;
        word_t     store_data;
        word_t     pc4;
        reg_addr_t rd;
        logic      reg_we;
        logic      mem_we;
        wb_sel_e   wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     alu;
        word_t     load_data;
        word_t     pc4;
        reg_addr_t rd;
        logic      reg_we;
        wb_sel_e   wb_sel;
    } mem_wb_t;

endpackage

// ==== hw/writeback_unit.sv ====
`timescale 1ns/10ps

module writeback_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  ex_mem_t   ex_mem,
    input  word_t     mem_dout,
    output reg_addr_t wb_addr,
    output logic      wb_we,
    output word_t     wb_data
);

    mem_wb_t mem_wb;

    always_ff @(posedge clk) begin
        mem_wb.alu       <= ex_mem.alu;
        mem_wb.load_data <= mem_dout; // Memory answers in the same cycle
        mem_wb.pc4       <= ex_mem.pc4;
        mem_wb.rd        <= ex_mem.rd;
        mem_wb.wb_sel    <= ex_mem.wb_sel;
        if (rst) begin
            mem_wb.valid  <= 1'b0;
            mem_wb.reg_we <= 1'b0;
        end else begin
            mem_wb.valid  <= ex_mem.valid;
            mem_wb.reg_we <= ex_mem.reg_we;
        end
    end

    always_comb begin
        case (mem_wb.wb_sel)
            WB_LOAD: wb_data = mem_wb.load_data;
            WB_PC4:  wb_data = mem_wb.pc4;
            default: wb_data = mem_wb.alu;
        endcase
    end

    assign wb_addr = mem_wb.rd;
    assign wb_we   = mem_wb.valid && mem_wb.reg_we;

endmodule

// ==== sim.f ====
hw/rv_pkg.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/hazard_unit.sv
hw/execute_unit.sv
hw/writeback_unit.sv
hw/rv_core.sv
sim/rv_core_assertions.sv
sim/rv_core_tb.sv

// ==== sim/rv_core_assertions.sv ====
`timescale 1ns/10ps

module rv_core_assertions import rv_pkg::*; (
    input logic  clk,
    input logic  rst,
    input word_t im_addr,
    input word_t mem_addr,
    input logic  mem_we
);

    int n_failed = 0; // Failed assertions so far

    a_we_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(mem_we))
        else begin
            n_failed++;
            $error("mem_we is unknown after reset");
        end

    a_mem_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_we |-> mem_addr[1:0] == 2'b00)
        else begin
            n_failed++;
            $error("Store address %h is not word-aligned", mem_addr);
        end

    a_im_aligned: assert property (@(posedge clk) disable iff (rst) im_addr[1:0] == 2'b00)
        else begin
            n_failed++;
            $error("Fetch address %h is not word-aligned", im_addr);
        end

    // First fetch comes from the reset vector
    a_reset_pc: assert property (@(posedge clk) $fell(rst) |-> im_addr == RESET_PC)
        else begin
            n_failed++;
            $error("Fetch address %h after reset is not the reset PC", im_addr);
        end

endmodule

bind rv_core rv_core_assertions u_assertions (.*);

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/10ps

module rv_core_tb import rv_pkg::*; ();

    localparam int TIMEOUT    = 2000;
    localparam int N_PROGRAMS = 20;
    localparam int DUMP_BASE  = 128; // Byte address of the register dump

    localparam int K_ADD = 0, K_SUB = 1, K_AND = 2, K_OR = 3, K_XOR = 4, K_SLT = 5;
    localparam int K_ADDI = 6, K_ANDI = 7, K_ORI = 8, K_XORI = 9, K_SLTI = 10;
    localparam int K_LUI = 11, K_LW = 12, K_SW = 13;
    localparam int K_BEQ = 14, K_BNE = 15, K_BLT = 16, K_JAL = 17;

    logic  clk;
    logic  rst;
    word_t im_addr;
    inst_t im_dout;
    word_t mem_addr;
    logic  mem_we;
    word_t mem_din;
    word_t mem_dout;

    inst_t imem [0:255];
    word_t dmem [0:63];

    // Current program, one entry per instruction
    int    kind [0:255];
    int    rd   [0:255];
    int    rs1  [0:255];
    int    rs2  [0:255];
    word_t imm  [0:255];
    int    halt_idx;

    word_t exp_addr [$];
    word_t exp_data [$];
    int    n_seen;

    rv_core u_dut (
        .clk(clk), .rst(rst),
        .im_addr(im_addr), .im_dout(im_dout),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_din(mem_din), .mem_dout(mem_dout)
    );

    assign im_dout  = imem[im_addr[9:2]];
    assign mem_dout = dmem[mem_addr[7:2]];

    function automatic word_t fill_word(int i);
        return 32'h9E37_79B1 * word_t'(i + 1) ^ 32'h0F0F_1234;
    endfunction

    function automatic int pick_src(int last);
        if ($urandom_range(0, 1) == 1)
            return last; // Back-to-back reuse
        return $urandom_range(0, 7);
    endfunction

    task automatic fail_run();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic gen_program();
        int    n_body;
        int    last;
        int    r;
        word_t raw;
        n_body = $urandom_range(40, 80);
        last = 1;
        for (int i = 0; i < n_body; i++) begin
            r = $urandom_range(0, 99);
            raw = $urandom;
            rd[i]  = $urandom_range(0, 7); // x0 as a target now and then
            rs1[i] = pick_src(last);
            rs2[i] = pick_src(last);
            imm[i] = {{20{raw[11]}}, raw[11:0]};
            if (r < 30) begin
                kind[i] = $urandom_range(K_ADD, K_SLT);
            end else if (r < 55) begin
                kind[i] = $urandom_range(K_ADDI, K_SLTI);
            end else if (r < 62) begin
                kind[i] = K_LUI;
                imm[i]  = raw & 32'hFFFF_F000;
            end else if (r < 84) begin
                kind[i] = (r < 74) ? K_LW : K_SW;
                rs1[i]  = 0;
                imm[i]  = word_t'($urandom_range(0, 31) * 4);
            end else if (i + 4 <= n_body) begin
                kind[i] = (r < 94) ? $urandom_range(K_BEQ, K_BLT) : K_JAL;
                imm[i]  = word_t'($urandom_range(2, 4) * 4); // Forward only
            end else begin
                kind[i] = K_ADDI;
            end
            if (rd[i] != 0)
                last = rd[i];
        end
        for (int x = 1; x < 8; x++) begin
            kind[n_body + x - 1] = K_SW;
            rs1[n_body + x - 1]  = 0;
            rs2[n_body + x - 1]  = x;
            imm[n_body + x - 1]  = word_t'(DUMP_BASE + (x - 1) * 4);
        end
        halt_idx = n_body + 7;
        kind[halt_idx] = K_JAL; // jal x0,0
        rd[halt_idx]   = 0;
        imm[halt_idx]  = '0;
    endtask

    function automatic inst_t encode(int i);
        reg_addr_t  d;
        reg_addr_t  s1;
        reg_addr_t  s2;
        word_t      m;
        logic [2:0] f3;
        d  = 5'(rd[i]);
        s1 = 5'(rs1[i]);
        s2 = 5'(rs2[i]);
        m  = imm[i];
        case (kind[i])
            K_ADD, K_SUB, K_ADDI, K_BEQ: f3 = 3'b000;
            K_AND, K_ANDI:               f3 = 3'b111;
            K_OR, K_ORI:                 f3 = 3'b110;
            K_XOR, K_XORI, K_BLT:        f3 = 3'b100;
            K_BNE:                       f3 = 3'b001;
            default:                     f3 = 3'b010; // slt, slti, lw, sw
        endcase
        case (kind[i])
            K_SUB: return {7'b0100000, s2, s1, f3, d, OP_REG};
            K_ADD, K_AND, K_OR, K_XOR, K_SLT: return {7'b0, s2, s1, f3, d, OP_REG};
            K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI: return {m[11:0], s1, f3, d, OP_IMM};
            K_LUI: return {m[31:12], d, OP_LUI};
            K_LW:  return {m[11:0], s1, f3, d, OP_LOAD};
            K_SW:  return {m[11:5], s2, s1, f3, m[4:0], OP_STORE};
            K_BEQ, K_BNE, K_BLT:
                return {m[12], m[10:5], s2, s1, f3, m[4:1], m[11], OP_BRANCH};
            default: return {m[20], m[10:1], m[11], m[19:12], d, OP_JAL};
        endcase
    endfunction

    function automatic word_t alu_ref(int k, word_t a, word_t b);
        case (k)
            K_SUB:         return a - b;
            K_AND, K_ANDI: return a & b;
            K_OR, K_ORI:   return a | b;
            K_XOR, K_XORI: return a ^ b;
            K_SLT, K_SLTI: return {31'b0, $signed(a) < $signed(b)};
            default:       return a + b;
        endcase
    endfunction

    // ISA model, builds the expected ordered store list
    task automatic run_model();
        word_t regs [0:7];
        word_t mem  [0:63];
        word_t a;
        word_t b;
        word_t addr;
        int    pc;
        int    next;
        int    jump;
        for (int i = 0; i < 8; i++)
            regs[i] = '0;
        for (int i = 0; i < 64; i++)
            mem[i] = fill_word(i);
        exp_addr.delete();
        exp_data.delete();
        pc = 0;
        while (pc != halt_idx) begin
            a    = regs[rs1[pc]];
            b    = regs[rs2[pc]];
            addr = a + imm[pc];
            next = pc + 1;
            jump = int'(imm[pc] >> 2);
            case (kind[pc])
                K_LUI: regs[rd[pc]] = imm[pc];
                K_LW:  regs[rd[pc]] = mem[addr[7:2]];
                K_SW: begin
                    mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                K_BEQ: if (a == b) next = pc + jump;
                K_BNE: if (a != b) next = pc + jump;
                K_BLT: if ($signed(a) < $signed(b)) next = pc + jump;
                K_JAL: begin
                    regs[rd[pc]] = word_t'(next * 4);
                    next = pc + jump;
                end
                K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI:
                    regs[rd[pc]] = alu_ref(kind[pc], a, imm[pc]);
                default: regs[rd[pc]] = alu_ref(kind[pc], a, b);
            endcase
            regs[0] = '0;
            pc = next;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Data memory and store monitor
    always @(posedge clk) begin
        if (rst) begin
            n_seen = 0;
            for (int i = 0; i < 64; i++)
                dmem[i] <= fill_word(i);
        end else if (mem_we) begin
            assert (n_seen < exp_addr.size())
                else begin
                    $display("Store to %h that the model never makes", mem_addr);
                    fail_run();
                end
            assert (mem_addr == exp_addr[n_seen])
                else begin
                    $display("[ERROR] mem_addr store %0d: got %h, expected %h",
                             n_seen, mem_addr, exp_addr[n_seen]);
                    fail_run();
                end
            assert (mem_din == exp_data[n_seen])
                else begin
                    $display("[ERROR] mem_din store %0d: got %h, expected %h",
                             n_seen, mem_din, exp_data[n_seen]);
                    fail_run();
                end
            dmem[mem_addr[7:2]] <= mem_din;
            n_seen = n_seen + 1;
        end
    end

    // Bound checker on the core ports
    always @(negedge clk) begin
        assert (u_dut.u_assertions.n_failed == 0)
            else begin
                $display("A bound assertion on the core ports failed");
                fail_run();
            end
    end

    initial begin
        int cycles;
        rst = 1'b1;
        void'($urandom(24759));
        for (int i = 0; i < 256; i++)
            imem[i] = NOP_INST;
        for (int p = 0; p < N_PROGRAMS; p++) begin
            @(posedge clk);
            rst <= 1'b1;
            gen_program();
            for (int i = 0; i < 256; i++)
                imem[i] = (i <= halt_idx) ? encode(i) : NOP_INST;
            run_model();
            repeat (8) @(posedge clk);
            rst <= 1'b0;
            @(negedge clk);
            assert (im_addr == RESET_PC)
                else begin
                    $display("[ERROR] im_addr after reset: got %h, expected %h",
                             im_addr, RESET_PC);
                    fail_run();
                end
            assert (mem_we == 1'b0)
                else begin
                    $display("[ERROR] mem_we after reset: got %h, expected %h", mem_we, 1'b0);
                    fail_run();
                end
            cycles = 0;
            while (!(n_seen == exp_addr.size() && im_addr == word_t'(halt_idx * 4))) begin
                @(negedge clk);
                cycles++;
                if (cycles >= TIMEOUT) begin
                    $display("Timeout: program %0d never reached the halt loop", p);
                    fail_run();
                end
            end
            repeat (8) @(negedge clk); // Window for stray stores
        end
        if (u_dut.u_assertions.n_failed == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("A bound assertion on the core ports failed");
            fail_run();
        end
    end

endmodule
